//--- fetch_frontend.f
design/fetch_pkg.sv
design/branch_predictor.sv
design/icache.sv
design/insn_fetcher.sv
design/fetch_frontend.sv
tb/insn_mem_model.sv
tb/fetch_frontend_asserts.sv
tb/fetch_frontend_tb.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - design/fetch_pkg.sv
  - design/branch_predictor.sv
  - design/icache.sv
  - design/insn_fetcher.sv
  - design/fetch_frontend.sv
  - target: test
    files:
      - tb/insn_mem_model.sv
      - tb/fetch_frontend_asserts.sv
      - tb/fetch_frontend_tb.sv

//--- tb/fetch_frontend_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_tb;

    import fetch_pkg::*;

    localparam int    mem_words      = 1024;
    // about 40 beats, a miss is under 10 cycles, plus one stall window, with wide margin
    localparam int    timeout_cycles = 4000;
    localparam addr_t jal_pc         = 32'h0000_0020;
    localparam addr_t jal_off        = 32'h0000_00e0;   // lands on 0x100
    localparam addr_t br_pc          = 32'h0000_0104;
    localparam addr_t br_off         = 32'h0000_0040;   // taken target 0x144

    logic  clk_in, br_reset, rdy_in, stall;
    logic  jalr_valid, redirect_valid, update_valid, update_taken;
    addr_t jalr_pc, redirect_pc, update_pc;
    logic  out_valid;
    insn_t out_insn;
    addr_t out_pc, out_next_pc;
    logic  wb_cyc, wb_stb, wb_ack;
    addr_t wb_adr;
    insn_t wb_dat_rd;

    integer seed = 32'hefd2;
    int     errors;
    int     cycle_count;
    int     cyc_samples;   // negedges with wb_cyc high
    logic   adr_seen;      // wb_cyc seen with wb_adr == watch_adr
    addr_t  watch_adr;

    fetch_frontend #(.cache_lines(64), .bht_entries(64)) i_dut (.*);
    insn_mem_model #(.words(mem_words)) i_mem (.*);
    bind icache fetch_frontend_asserts i_asserts (.*);

    initial clk_in = 1'b0;
    always #2 clk_in = ~clk_in;

    function automatic insn_t encode_jal(input addr_t off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    // beq x1, x2
    function automatic insn_t encode_branch(input addr_t off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    // addi x1, x0, word index outside the two planted control words
    function automatic insn_t image_word(input addr_t addr);
        if (addr == jal_pc) return encode_jal(jal_off);
        if (addr == br_pc) return encode_branch(br_off);
        return {addr[13:2], 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_beat();
        do begin
            @(negedge clk_in);
            if (wb_cyc) cyc_samples++;
            if (wb_cyc && wb_adr == watch_adr) adr_seen = 1'b1;
        end while (!out_valid);
    endtask

    task automatic expect_beat(input addr_t pc, input addr_t next_pc);
        wait_beat();
        check_value("out_pc", out_pc, pc);
        check_value("out_insn", out_insn, image_word(pc));
        check_value("out_next_pc", out_next_pc, next_pc);
    endtask

    // held for exactly one rising edge
    task automatic apply_redirect(input logic rv, input addr_t rpc,
                                  input logic jv, input addr_t jpc);
        redirect_valid = rv;
        redirect_pc    = rpc;
        jalr_valid     = jv;
        jalr_pc        = jpc;
        @(negedge clk_in);
        redirect_valid = 1'b0;
        jalr_valid     = 1'b0;
    endtask

    task automatic train_branch(input addr_t pc, input logic taken, input int n);
        update_valid = 1'b1;
        update_pc    = pc;
        update_taken = taken;
        repeat (n) @(negedge clk_in);
        update_valid = 1'b0;
    endtask

    task automatic test_sequential();
        int k;
        for (k = 0; k < 8; k++) begin
            expect_beat(addr_t'(k * 4), addr_t'(k * 4 + 4));
        end
    endtask

    task automatic test_jal();
        expect_beat(jal_pc, jal_pc + jal_off);
        expect_beat(jal_pc + jal_off, jal_pc + jal_off + 4);
    endtask

    task automatic test_branch();
        expect_beat(br_pc, br_pc + 4);              // counter starts weakly not taken
        train_branch(br_pc, 1'b1, 2);
        apply_redirect(1'b1, br_pc, 1'b0, '0);
        expect_beat(br_pc, br_pc + br_off);
        expect_beat(br_pc + br_off, br_pc + br_off + 4);
        train_branch(br_pc, 1'b0, 2);
        apply_redirect(1'b1, br_pc, 1'b0, '0);
        expect_beat(br_pc, br_pc + 4);
        expect_beat(br_pc + 4, br_pc + 8);
    endtask

    task automatic test_redirects();
        apply_redirect(1'b1, 32'h200, 1'b1, 32'h300);   // reorder buffer wins
        expect_beat(32'h200, 32'h204);
        expect_beat(32'h204, 32'h208);
        expect_beat(32'h208, 32'h20c);
        apply_redirect(1'b0, '0, 1'b1, 32'h280);
        expect_beat(32'h280, 32'h284);
        expect_beat(32'h284, 32'h288);
    endtask

    task automatic test_stall();
        int n;
        int i;
        expect_beat(32'h288, 32'h28c);
        @(negedge clk_in);
        n     = 10 + ($unsigned($random(seed)) % 8);  // outlasts a worst-case refill
        stall = 1'b1;                               // next request is already out
        for (i = 0; i < n; i++) begin
            @(negedge clk_in);
            if (out_valid) begin
                $display("out_valid pulsed while stall was held (pc %h)", out_pc);
                errors++;
            end
        end
        stall = 1'b0;
        expect_beat(32'h28c, 32'h290);
        expect_beat(32'h290, 32'h294);
        expect_beat(32'h294, 32'h298);
    endtask

    task automatic test_cache();
        apply_redirect(1'b1, 32'h280, 1'b0, '0);
        expect_beat(32'h280, 32'h284);
        cyc_samples = 0;
        expect_beat(32'h284, 32'h288);
        expect_beat(32'h288, 32'h28c);
        if (cyc_samples != 0) begin
            $display("wishbone cycle seen while refetching lines already in the cache");
            errors++;
        end
        watch_adr = 32'h380;                        // same line index as 0x280
        adr_seen  = 1'b0;
        apply_redirect(1'b1, 32'h380, 1'b0, '0);
        expect_beat(32'h380, 32'h384);
        if (!adr_seen) begin
            $display("no wishbone refill at address 0x380 after the line was aliased");
            errors++;
        end
    endtask

    initial begin
        int k;
        int asrt;
        errors         = 0;
        cyc_samples    = 0;
        adr_seen       = 1'b0;
        watch_adr      = '1;
        br_reset       = 1'b1;
        rdy_in         = 1'b1;
        stall          = 1'b0;
        jalr_valid     = 1'b0;
        jalr_pc        = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        update_valid   = 1'b0;
        update_pc      = '0;
        update_taken   = 1'b0;
        for (k = 0; k < mem_words; k++) begin
            i_mem.mem[k] = image_word(addr_t'(k) << 2);
        end
        repeat (4) @(negedge clk_in);
        br_reset = 1'b0;

        test_sequential();
        test_jal();
        test_branch();
        test_redirects();
        test_stall();
        test_cache();

        asrt = i_dut.i_icache.i_asserts.assert_failures;
        $display("checks failed: %0d, assertion failures: %0d", errors, asrt);
        if (errors == 0 && asrt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("timeout: tests still running after %0d cycles", timeout_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/fetch_frontend_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_asserts (
    input logic             clk_in,
    input logic             br_reset,
    input logic             fetch_valid,
    input logic             insn_ready,
    input logic             wb_cyc,
    input logic             wb_stb,
    input fetch_pkg::addr_t wb_adr,
    input logic             wb_ack
);

    int assert_failures = 0;

    a_stb_in_cyc: assert property (@(posedge clk_in) disable iff (br_reset)
        wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high outside a wishbone cycle");
            assert_failures++;
        end

    // request held unchanged until the slave acks
    a_bus_held: assert property (@(posedge clk_in) disable iff (br_reset)
        (wb_cyc && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr)))
        else begin
            $error("wishbone request changed or dropped before ack");
            assert_failures++;
        end

    a_drop_after_ack: assert property (@(posedge clk_in) disable iff (br_reset)
        (wb_cyc && wb_ack) |=> !wb_cyc)
        else begin
            $error("wb_cyc still high after ack");
            assert_failures++;
        end

    a_ready_after_valid: assert property (@(posedge clk_in) disable iff (br_reset)
        insn_ready |-> $past(fetch_valid))
        else begin
            $error("insn_ready without fetch_valid in the previous cycle");
            assert_failures++;
        end

endmodule

`default_nettype wire

//--- tb/insn_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module insn_mem_model #(
    parameter int words = 1024
) (
    input  logic             clk_in,
    input  logic             br_reset,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  fetch_pkg::addr_t wb_adr,
    output fetch_pkg::insn_t wb_dat_rd,
    output logic             wb_ack
);

    import fetch_pkg::*;

    localparam int aw = $clog2(words);

    insn_t      mem [words];     // program image, loaded by the testbench
    integer     seed = 32'hefd2;
    logic       busy;
    logic [1:0] wait_cnt;        // extra cycles before ack

    always @(posedge clk_in) begin
        if (br_reset) begin
            busy      <= 1'b0;
            wait_cnt  <= '0;
            wb_ack    <= 1'b0;
            wb_dat_rd <= '0;
        end else begin
            wb_ack <= 1'b0;
            if (busy) begin
                if (wait_cnt == 2'd0) begin
                    wb_ack    <= 1'b1;
                    wb_dat_rd <= mem[wb_adr[aw+1:2]];
                    busy      <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else if (wb_cyc && wb_stb && !wb_ack) begin
                busy     <= 1'b1;
                wait_cnt <= 2'($unsigned($random(seed)));
            end
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_frontend.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend #(
    parameter int cache_lines = 64,
    parameter int bht_entries = 64
) (
    input  logic             clk_in,
    input  logic             br_reset,
    input  logic             rdy_in,
    input  logic             stall,
    input  logic             jalr_valid,
    input  fetch_pkg::addr_t jalr_pc,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             update_valid,
    input  fetch_pkg::addr_t update_pc,
    input  logic             update_taken,
    output logic             out_valid,
    output fetch_pkg::insn_t out_insn,
    output fetch_pkg::addr_t out_pc,
    output fetch_pkg::addr_t out_next_pc,
    output logic             wb_cyc,
    output logic             wb_stb,
    output fetch_pkg::addr_t wb_adr,
    input  fetch_pkg::insn_t wb_dat_rd,
    input  logic             wb_ack
);

    import fetch_pkg::*;

    // fetcher <-> cache
    logic  fetch_valid;
    addr_t fetch_pc;
    logic  insn_ready;
    insn_t insn;

    // fetcher <-> predictor
    insn_t pred_insn;
    addr_t pred_pc;
    addr_t pred_next_pc;

    insn_fetcher i_fetcher (
        .clk_in         (clk_in),
        .br_reset       (br_reset),
        .rdy_in         (rdy_in),
        .stall          (stall),
        .jalr_valid     (jalr_valid),
        .jalr_pc        (jalr_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .insn_ready     (insn_ready),
        .insn           (insn),
        .pred_insn      (pred_insn),
        .pred_pc        (pred_pc),
        .pred_next_pc   (pred_next_pc),
        .out_valid      (out_valid),
        .out_insn       (out_insn),
        .out_pc         (out_pc),
        .out_next_pc    (out_next_pc)
    );

    icache #(
        .cache_lines (cache_lines)
    ) i_icache (
        .clk_in      (clk_in),
        .br_reset    (br_reset),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .insn_ready  (insn_ready),
        .insn        (insn),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_adr      (wb_adr),
        .wb_dat_rd   (wb_dat_rd),
        .wb_ack      (wb_ack)
    );

    branch_predictor #(
        .bht_entries (bht_entries)
    ) i_bpred (
        .clk_in       (clk_in),
        .br_reset     (br_reset),
        .pred_insn    (pred_insn),
        .pred_pc      (pred_pc),
        .pred_next_pc (pred_next_pc),
        .update_valid (update_valid),
        .update_pc    (update_pc),
        .update_taken (update_taken)
    );

endmodule

`default_nettype wire

//--- design/insn_fetcher.sv
`timescale 1ns/10ps
`default_nettype none

module insn_fetcher (
    input  logic             clk_in,
    input  logic             br_reset,
    input  logic             rdy_in,        // low freezes everything
    input  logic             stall,         // decoder back-pressure

    input  logic             jalr_valid,
    input  fetch_pkg::addr_t jalr_pc,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,

    // instruction cache
    output logic             fetch_valid,
    output fetch_pkg::addr_t fetch_pc,
    input  logic             insn_ready,
    input  fetch_pkg::insn_t insn,

    // branch predictor
    output fetch_pkg::insn_t pred_insn,
    output fetch_pkg::addr_t pred_pc,
    input  fetch_pkg::addr_t pred_next_pc,

    // decoder
    output logic             out_valid,
    output fetch_pkg::insn_t out_insn,
    output fetch_pkg::addr_t out_pc,
    output fetch_pkg::addr_t out_next_pc
);

    import fetch_pkg::*;

    typedef enum logic {
        st_idle,    // no request outstanding
        st_wait     // fetch_valid high, waiting on the cache
    } fetch_state_e;

    fetch_state_e state;
    addr_t        pc;

    logic  redirect;
    addr_t redirect_target;
    logic  is_jal;
    addr_t next_pc;
    logic  take;

    // pc only moves on accept or redirect, both of which drop fetch_valid
    assign fetch_pc  = pc;
    assign pred_pc   = pc;
    assign pred_insn = insn;

    // reorder buffer wins over the decoder's jalr
    assign redirect        = redirect_valid || jalr_valid;
    assign redirect_target = redirect_valid ? redirect_pc : jalr_pc;

    assign take = (state == st_wait) && insn_ready && !stall;

    always_comb begin
        is_jal = (insn[6:0] == opc_jal);
        if (is_jal) begin
            next_pc = pc + imm_j(insn);  // target known without prediction
        end else begin
            next_pc = pred_next_pc;
        end
    end

    always_ff @(posedge clk_in) begin
        if (br_reset) begin
            state       <= st_idle;
            pc          <= '0;
            fetch_valid <= 1'b0;
            out_valid   <= 1'b0;
        end else if (rdy_in) begin
            out_valid <= 1'b0;             // single cycle pulse
            if (redirect) begin
                // abandon whatever is in flight
                pc          <= redirect_target;
                fetch_valid <= 1'b0;
                state       <= st_idle;
            end else begin
                case (state)
                    st_idle: begin
                        if (!stall) begin
                            fetch_valid <= 1'b1;
                            state       <= st_wait;
                        end
                    end
                    st_wait: begin
                        if (take) begin
                            pc          <= next_pc;
                            fetch_valid <= 1'b0;
                            out_valid   <= 1'b1;
                            state       <= st_idle;
                        end
                    end
                endcase
            end
        end
    end

    // decoder payload qualified by out_valid
    always_ff @(posedge clk_in) begin
        if (rdy_in && !redirect && take) begin
            out_insn    <= insn;
            out_pc      <= pc;
            out_next_pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

//--- design/icache.sv
`timescale 1ns/10ps
`default_nettype none

module icache #(
    parameter int cache_lines = 64     // power of two, at least 2
) (
    input  logic             clk_in,
    input  logic             br_reset,

    // fetcher side
    input  logic             fetch_valid,
    input  fetch_pkg::addr_t fetch_pc,
    output logic             insn_ready,
    output fetch_pkg::insn_t insn,

    // wishbone classic, read only
    output logic             wb_cyc,
    output logic             wb_stb,
    output fetch_pkg::addr_t wb_adr,
    input  fetch_pkg::insn_t wb_dat_rd,
    input  logic             wb_ack
);

    import fetch_pkg::*;

    localparam int idx_bits = $clog2(cache_lines);
    localparam int tag_bits = xlen - idx_bits - 2;

    logic [tag_bits-1:0]    tag_mem [cache_lines];
    insn_t                  data_mem [cache_lines];
    logic [cache_lines-1:0] valid_q;

    logic [idx_bits-1:0] req_idx;
    logic [tag_bits-1:0] req_tag;
    logic [idx_bits-1:0] fill_idx;
    logic [tag_bits-1:0] fill_tag;

    logic hit;
    logic accept;
    logic start_refill;
    logic answer_hit;
    logic answer_fill;
    logic abandoned;          // request withdrawn during the refill

    // word address modulo cache_lines
    assign req_idx  = fetch_pc[idx_bits+1:2];
    assign req_tag  = fetch_pc[xlen-1:idx_bits+2];
    assign fill_idx = wb_adr[idx_bits+1:2];
    assign fill_tag = wb_adr[xlen-1:idx_bits+2];

    assign hit = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);

    // a new request is only taken once the previous answer is gone
    // and no bus cycle is running
    assign accept       = fetch_valid && !insn_ready && !wb_cyc;
    assign answer_hit   = accept && hit;
    assign start_refill = accept && !hit;
    assign answer_fill  = wb_cyc && wb_ack && fetch_valid && !abandoned;

    always_ff @(posedge clk_in) begin
        if (br_reset) begin
            insn_ready <= 1'b0;
            wb_cyc     <= 1'b0;
            wb_stb     <= 1'b0;
            abandoned  <= 1'b0;
            valid_q    <= '0;
        end else if (wb_cyc) begin
            if (wb_ack) begin
                wb_cyc            <= 1'b0;
                wb_stb            <= 1'b0;
                valid_q[fill_idx] <= 1'b1;  // line fills even if dropped
                if (answer_fill) begin
                    insn_ready <= 1'b1;
                end
            end else if (!fetch_valid) begin
                abandoned <= 1'b1;
            end
        end else if (insn_ready) begin
            // hold the answer until the fetcher lets go
            if (!fetch_valid) begin
                insn_ready <= 1'b0;
            end
        end else if (answer_hit) begin
            insn_ready <= 1'b1;
        end else if (start_refill) begin
            wb_cyc    <= 1'b1;
            wb_stb    <= 1'b1;
            abandoned <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (answer_hit) begin
            insn <= data_mem[req_idx];
        end else if (answer_fill) begin
            insn <= wb_dat_rd;            // forward straight from the bus
        end
        if (start_refill) begin
            wb_adr <= {fetch_pc[xlen-1:2], 2'b00};
        end
    end

    // line write at the ack edge
    always_ff @(posedge clk_in) begin
        if (wb_cyc && wb_ack) begin
            tag_mem[fill_idx]  <= fill_tag;
            data_mem[fill_idx] <= wb_dat_rd;
        end
    end

endmodule

`default_nettype wire

//--- design/branch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module branch_predictor #(
    parameter int bht_entries = 64     // power of two, at least 2
) (
    input  logic             clk_in,
    input  logic             br_reset,

    // lookup from the fetcher
    input  fetch_pkg::insn_t pred_insn,
    input  fetch_pkg::addr_t pred_pc,
    output fetch_pkg::addr_t pred_next_pc,

    // training from the reorder buffer
    input  logic             update_valid,
    input  fetch_pkg::addr_t update_pc,
    input  logic             update_taken
);

    import fetch_pkg::*;

    localparam int idx_bits = $clog2(bht_entries);

    ctr_t bht [bht_entries];

    logic [idx_bits-1:0] pred_idx;
    logic [idx_bits-1:0] upd_idx;
    logic                is_branch;
    logic                predict_taken;
    ctr_t                upd_ctr;

    // index skips the byte offset
    assign pred_idx = pred_pc[idx_bits+1:2];
    assign upd_idx  = update_pc[idx_bits+1:2];

    always_comb begin
        is_branch     = (pred_insn[6:0] == opc_branch);
        predict_taken = is_branch && bht[pred_idx][1];   // counter >= 2
        if (predict_taken) begin
            pred_next_pc = pred_pc + imm_b(pred_insn);
        end else begin
            pred_next_pc = pred_pc + 32'd4;
        end
    end

    // one saturating step toward the outcome
    always_comb begin
        upd_ctr = bht[upd_idx];
        if (update_taken) begin
            if (upd_ctr != ctr_max) begin
                upd_ctr = upd_ctr + 2'd1;
            end
        end else if (upd_ctr != ctr_min) begin
            upd_ctr = upd_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (br_reset) begin
            for (int i = 0; i < bht_entries; i++) begin
                bht[i] <= ctr_weak_nt;
            end
        end else if (update_valid) begin
            bht[upd_idx] <= upd_ctr;
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] addr_t;
    typedef logic [xlen-1:0] insn_t;

    // major opcodes, bits [6:0]
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // 2-bit saturating branch counter, msb set means taken
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_weak_nt = 2'b01;   // reset value
    localparam ctr_t ctr_max     = 2'b11;
    localparam ctr_t ctr_min     = 2'b00;

    // J-type offset: imm[20|10:1|11|19:12]
    function automatic addr_t imm_j(input insn_t i);
        return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
    endfunction

    // B-type offset: imm[12|10:5] in [31:25], imm[4:1|11] in [11:7]
    function automatic addr_t imm_b(input insn_t i);
        return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
    endfunction

endpackage

`default_nettype wire
